/* verilog/alu_pkg.sv */
package alu_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////

    localparam int DATA_W     = 32;
    localparam int PC_W       = 32;
    localparam int ROB_ID_W   = 6;
    localparam int REG_ADDR_W = 5;
    localparam int OFFSET_W   = 20;
    localparam int OPCODE_W   = 7;

    //////////////////////////////////////////////////////////////////////
    // Opcodes
    //////////////////////////////////////////////////////////////////////

    // Register-register and immediate arithmetic
    localparam logic [OPCODE_W-1:0] OP_ADD  = 7'h00;
    localparam logic [OPCODE_W-1:0] OP_SUB  = 7'h01;
    localparam logic [OPCODE_W-1:0] OP_ADDI = 7'h02;
    localparam logic [OPCODE_W-1:0] OP_SLL  = 7'h03;
    localparam logic [OPCODE_W-1:0] OP_SRL  = 7'h04;
    localparam logic [OPCODE_W-1:0] OP_MOV  = 7'h05;

    // Loads and stores
    localparam logic [OPCODE_W-1:0] OP_LDB  = 7'h10;
    localparam logic [OPCODE_W-1:0] OP_LDW  = 7'h11;
    localparam logic [OPCODE_W-1:0] OP_STB  = 7'h12;
    localparam logic [OPCODE_W-1:0] OP_STW  = 7'h13;

    // Branches and jump
    localparam logic [OPCODE_W-1:0] OP_BEQ  = 7'h30;
    localparam logic [OPCODE_W-1:0] OP_BNE  = 7'h31;
    localparam logic [OPCODE_W-1:0] OP_BLT  = 7'h32;
    localparam logic [OPCODE_W-1:0] OP_BGT  = 7'h33;
    localparam logic [OPCODE_W-1:0] OP_BLE  = 7'h34;
    localparam logic [OPCODE_W-1:0] OP_BGE  = 7'h35;
    localparam logic [OPCODE_W-1:0] OP_JUMP = 7'h36;

    //////////////////////////////////////////////////////////////////////
    // Shared records
    //////////////////////////////////////////////////////////////////////

    typedef enum logic
    {
        SIZE_BYTE = 1'b0,
        SIZE_WORD = 1'b1
    } mem_size_t;

    // Decoded instruction with operands already resolved
    typedef struct packed
    {
        logic [OPCODE_W-1:0]   opcode;
        logic [REG_ADDR_W-1:0] rd_addr;
        logic [DATA_W-1:0]     ra_data;
        logic [DATA_W-1:0]     rb_data;
        logic [OFFSET_W-1:0]   offset;
        logic [ROB_ID_W-1:0]   instr_id;
        logic [PC_W-1:0]       pc;
    } alu_req_t;

    typedef struct packed
    {
        logic      is_arith;
        logic      is_mov;
        logic      is_branch;
        logic      is_jump;
        logic      is_mem;
        logic      is_store;
        mem_size_t mem_size;
    } op_class_t;

    typedef struct packed
    {
        logic [PC_W-1:0]       pc;
        logic [ROB_ID_W-1:0]   instr_id;
        logic [REG_ADDR_W-1:0] rd_addr;
        logic [DATA_W-1:0]     addr;
        logic [DATA_W-1:0]     data;
        logic                  is_store;
        mem_size_t             size;
    } dcache_req_t;

    typedef struct packed
    {
        logic [ROB_ID_W-1:0]   instr_id;
        logic [PC_W-1:0]       pc;
        logic                  rf_wen;
        logic [REG_ADDR_W-1:0] rf_dest;
        logic [DATA_W-1:0]     rf_data;
        logic                  xcpt_overflow;
    } wb_req_t;

    typedef struct packed
    {
        logic            taken;
        logic [PC_W-1:0] target;
    } branch_res_t;

endpackage

/* verilog/alu_decode.sv */
`timescale 1ns/1ps

module alu_decode
(
    input  alu_pkg::alu_req_t  req,
    output alu_pkg::op_class_t op_class
);
    import alu_pkg::*;

    always_comb
    begin
        // Unknown opcodes leave every flag low
        op_class          = '0;
        op_class.mem_size = SIZE_WORD;

        case (req.opcode)
            OP_ADD, OP_SUB, OP_ADDI, OP_SLL, OP_SRL:
            begin
                op_class.is_arith = 1'b1;
            end
            OP_MOV:
            begin
                op_class.is_mov = 1'b1;
            end
            OP_BEQ, OP_BNE, OP_BLT, OP_BGT, OP_BLE, OP_BGE:
            begin
                op_class.is_branch = 1'b1;
            end
            OP_JUMP:
            begin
                op_class.is_jump = 1'b1;
            end
            OP_LDB:
            begin
                op_class.is_mem   = 1'b1;
                op_class.mem_size = SIZE_BYTE;
            end
            OP_LDW:
            begin
                op_class.is_mem = 1'b1;
            end
            OP_STB:
            begin
                op_class.is_mem   = 1'b1;
                op_class.is_store = 1'b1;
                op_class.mem_size = SIZE_BYTE;
            end
            OP_STW:
            begin
                op_class.is_mem   = 1'b1;
                op_class.is_store = 1'b1;
            end
        endcase
    end

endmodule

/* verilog/alu_arith.sv */
`timescale 1ns/1ps

module alu_arith
(
    input  alu_pkg::alu_req_t          req,
    input  alu_pkg::op_class_t         op_class,
    output logic [alu_pkg::DATA_W-1:0] wb_data,
    output logic                       overflow
);
    import alu_pkg::*;

    // Operands widened so carries and shifted-out bits land in the upper half
    logic [2*DATA_W-1:0] ra_wide;
    logic [2*DATA_W-1:0] rb_wide;
    logic [2*DATA_W-1:0] imm_wide;
    logic [2*DATA_W-1:0] result;

    assign ra_wide  = {{DATA_W{1'b0}}, req.ra_data};
    assign rb_wide  = {{DATA_W{1'b0}}, req.rb_data};
    assign imm_wide = {{(2*DATA_W-OFFSET_W){1'b0}}, req.offset};

    always_comb
    begin
        result   = '0;
        overflow = 1'b0;

        if (op_class.is_mov)
        begin
            result = ra_wide;
        end
        else if (op_class.is_arith)
        begin
            case (req.opcode)
                OP_ADD:
                begin
                    result   = ra_wide + rb_wide;
                    overflow = (result[2*DATA_W-1:DATA_W] != '0);
                end
                OP_ADDI:
                begin
                    result   = ra_wide + imm_wide;
                    overflow = (result[2*DATA_W-1:DATA_W] != '0);
                end
                OP_SLL:
                begin
                    result   = ra_wide << req.offset;
                    overflow = (result[2*DATA_W-1:DATA_W] != '0);
                end
                OP_SRL:
                begin
                    result = ra_wide >> req.offset;
                end
                // SUB wraps without an overflow flag
                default:
                begin
                    result = ra_wide - rb_wide;
                end
            endcase
        end
    end

    assign wb_data = result[DATA_W-1:0];

endmodule

/* verilog/alu_branch.sv */
`timescale 1ns/1ps

module alu_branch
(
    input  alu_pkg::alu_req_t    req,
    input  alu_pkg::op_class_t   op_class,
    output alu_pkg::branch_res_t branch
);
    import alu_pkg::*;

    logic cond;

    // Unsigned compare of ra against rb
    always_comb
    begin
        case (req.opcode)
            OP_BEQ:  cond = (req.ra_data == req.rb_data);
            OP_BNE:  cond = (req.ra_data != req.rb_data);
            OP_BLT:  cond = (req.ra_data <  req.rb_data);
            OP_BGT:  cond = (req.ra_data >  req.rb_data);
            OP_BLE:  cond = (req.ra_data <= req.rb_data);
            OP_BGE:  cond = (req.ra_data >= req.rb_data);
            default: cond = 1'b0;
        endcase
    end

    always_comb
    begin
        branch.taken = (op_class.is_branch & cond) | op_class.is_jump;

        // Target only meaningful when taken
        if (branch.taken)
        begin
            branch.target = {{(PC_W-OFFSET_W){1'b0}}, req.offset};
        end
        else
        begin
            branch.target = '0;
        end
    end

endmodule

/* verilog/alu_agen.sv */
`timescale 1ns/1ps

module alu_agen
(
    input  alu_pkg::alu_req_t    req,
    input  alu_pkg::op_class_t   op_class,
    output alu_pkg::dcache_req_t mem
);
    import alu_pkg::*;

    logic [DATA_W-1:0] base;
    logic [DATA_W-1:0] imm;

    // Stores take the base from rb, loads from ra
    assign base = op_class.is_store ? req.rb_data : req.ra_data;
    assign imm  = {{(DATA_W-OFFSET_W){1'b0}}, req.offset};

    always_comb
    begin
        mem.pc       = req.pc;
        mem.instr_id = req.instr_id;
        mem.rd_addr  = req.rd_addr;

        // Wraps at DATA_W without raising overflow
        mem.addr     = base + imm;

        // Store data always comes from ra
        mem.data     = req.ra_data;
        mem.is_store = op_class.is_store;
        mem.size     = op_class.mem_size;
    end

endmodule

/* verilog/alu_route.sv */
`timescale 1ns/1ps

module alu_route
(
    input  logic                         clock,
    input  logic                         rst_n,
    input  logic                         flush,
    input  logic                         dcache_ready,
    input  logic [alu_pkg::ROB_ID_W-1:0] rob_tail,
    input  logic                         req_valid,
    input  alu_pkg::alu_req_t            req,
    input  alu_pkg::op_class_t           op_class,
    input  logic [alu_pkg::DATA_W-1:0]   wb_data,
    input  logic                         overflow,
    input  alu_pkg::branch_res_t         branch,
    input  alu_pkg::dcache_req_t         mem,

    output logic                         dcache_valid,
    output alu_pkg::dcache_req_t         dcache_req,
    output logic                         wb_valid,
    output alu_pkg::wb_req_t             wb_req,
    output logic                         wb_mem_blocked,
    output alu_pkg::dcache_req_t         wb_dcache_req,
    output logic                         take_branch,
    output logic [alu_pkg::PC_W-1:0]     branch_pc
);
    import alu_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Destination selection
    //////////////////////////////////////////////////////////////////////

    logic        accept;
    logic        mem_oldest;
    logic        to_wb;
    wb_req_t     wb_next;
    dcache_req_t mem_q;

    assign accept = req_valid & ~flush;

    // Oldest in flight and cache free to take it
    assign mem_oldest = (rob_tail == req.instr_id) & dcache_ready;

    assign to_wb = op_class.is_arith | op_class.is_mov
                 | op_class.is_branch | op_class.is_jump;

    always_comb
    begin
        wb_next.instr_id      = req.instr_id;
        wb_next.pc            = req.pc;
        wb_next.rf_wen        = op_class.is_arith | op_class.is_mov;
        wb_next.rf_dest       = req.rd_addr;
        wb_next.rf_data       = wb_data;
        wb_next.xcpt_overflow = overflow;
    end

    //////////////////////////////////////////////////////////////////////
    // Output registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            dcache_valid   <= 1'b0;
            wb_valid       <= 1'b0;
            wb_mem_blocked <= 1'b0;
            take_branch    <= 1'b0;
        end
        else
        begin
            dcache_valid   <= accept & op_class.is_mem & mem_oldest;
            wb_mem_blocked <= accept & op_class.is_mem & ~mem_oldest;
            wb_valid       <= accept & to_wb;
            take_branch    <= accept & branch.taken;
        end
    end

    // Payloads follow the strobe
    always_ff @(posedge clock)
    begin
        if (req_valid)
        begin
            wb_req    <= wb_next;
            mem_q     <= mem;
            branch_pc <= branch.target;
        end
    end

    // One memory payload serves both the cache and the blocked path
    assign dcache_req    = mem_q;
    assign wb_dcache_req = mem_q;

endmodule

/* verilog/alu_top.sv */
`timescale 1ns/1ps

module alu_top
(
    input  logic                         clock,
    input  logic                         rst_n,
    input  logic                         flush,
    input  logic                         dcache_ready,
    input  logic [alu_pkg::ROB_ID_W-1:0] rob_tail,
    input  logic                         req_valid,
    input  alu_pkg::alu_req_t            req,

    // Data cache side
    output logic                         dcache_valid,
    output alu_pkg::dcache_req_t         dcache_req,

    // Writeback side
    output logic                         wb_valid,
    output alu_pkg::wb_req_t             wb_req,
    output logic                         wb_mem_blocked,
    output alu_pkg::dcache_req_t         wb_dcache_req,

    // Fetch redirect
    output logic                         take_branch,
    output logic [alu_pkg::PC_W-1:0]     branch_pc
);
    import alu_pkg::*;

    op_class_t         op_class;
    logic [DATA_W-1:0] wb_data;
    logic              overflow;
    branch_res_t       branch;
    dcache_req_t       mem;

    //////////////////////////////////////////////////////////////////////
    // Input side
    //////////////////////////////////////////////////////////////////////

    alu_decode alu_decode_inst
    (
        .req      (req),
        .op_class (op_class)
    );

    //////////////////////////////////////////////////////////////////////
    // Processing
    //////////////////////////////////////////////////////////////////////

    alu_arith alu_arith_inst
    (
        .req      (req),
        .op_class (op_class),
        .wb_data  (wb_data),
        .overflow (overflow)
    );

    alu_branch alu_branch_inst
    (
        .req      (req),
        .op_class (op_class),
        .branch   (branch)
    );

    alu_agen alu_agen_inst
    (
        .req      (req),
        .op_class (op_class),
        .mem      (mem)
    );

    //////////////////////////////////////////////////////////////////////
    // Output side
    //////////////////////////////////////////////////////////////////////

    alu_route alu_route_inst
    (
        .clock          (clock),
        .rst_n          (rst_n),
        .flush          (flush),
        .dcache_ready   (dcache_ready),
        .rob_tail       (rob_tail),
        .req_valid      (req_valid),
        .req            (req),
        .op_class       (op_class),
        .wb_data        (wb_data),
        .overflow       (overflow),
        .branch         (branch),
        .mem            (mem),
        .dcache_valid   (dcache_valid),
        .dcache_req     (dcache_req),
        .wb_valid       (wb_valid),
        .wb_req         (wb_req),
        .wb_mem_blocked (wb_mem_blocked),
        .wb_dcache_req  (wb_dcache_req),
        .take_branch    (take_branch),
        .branch_pc      (branch_pc)
    );

endmodule

/* bench/alu_ref.svh */
`ifndef ALU_REF_SVH
`define ALU_REF_SVH

// Expected DUT outputs for one cycle of stimulus
typedef struct packed
{
    logic            dcache_valid;
    logic            wb_valid;
    logic            wb_mem_blocked;
    logic            take_branch;
    logic [PC_W-1:0] branch_pc;
    wb_req_t         wb_req;
    dcache_req_t     mem_req;
} expect_t;

// Unsigned compare with jump always taken
function automatic logic branch_holds(input logic [OPCODE_W-1:0] op,
                                      input logic [DATA_W-1:0]   a,
                                      input logic [DATA_W-1:0]   b);
    case (op)
        OP_BEQ:  return a == b;
        OP_BNE:  return a != b;
        OP_BLT:  return a < b;
        OP_BGT:  return a > b;
        OP_BLE:  return a <= b;
        OP_BGE:  return a >= b;
        OP_JUMP: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

function automatic expect_t expected_outputs(input alu_req_t            r,
                                             input logic                valid,
                                             input logic [ROB_ID_W-1:0] tail,
                                             input logic                ready,
                                             input logic                flush_in);
    expect_t             e;
    logic [2*DATA_W-1:0] wide;
    logic [DATA_W-1:0]   imm;
    logic                live;
    logic                store;
    logic                oldest;

    e    = '0;
    imm  = {{(DATA_W-OFFSET_W){1'b0}}, r.offset};
    live = valid & ~flush_in;

    e.wb_req.instr_id  = r.instr_id;
    e.wb_req.pc        = r.pc;
    e.wb_req.rf_dest   = r.rd_addr;
    e.mem_req.pc       = r.pc;
    e.mem_req.instr_id = r.instr_id;
    e.mem_req.rd_addr  = r.rd_addr;
    e.mem_req.data     = r.ra_data;

    // Double width so carries and shifted-out bits are kept
    case (r.opcode)
        OP_ADD:  wide = {{DATA_W{1'b0}}, r.ra_data} + {{DATA_W{1'b0}}, r.rb_data};
        OP_ADDI: wide = {{DATA_W{1'b0}}, r.ra_data} + {{DATA_W{1'b0}}, imm};
        OP_SLL:  wide = {{DATA_W{1'b0}}, r.ra_data} << r.offset;
        OP_SUB:  wide = {{DATA_W{1'b0}}, r.ra_data - r.rb_data};
        OP_SRL:  wide = {{DATA_W{1'b0}}, r.ra_data >> r.offset};
        OP_MOV:  wide = {{DATA_W{1'b0}}, r.ra_data};
        default: wide = '0;
    endcase
    e.wb_req.rf_data       = wide[DATA_W-1:0];
    e.wb_req.xcpt_overflow = (wide[2*DATA_W-1:DATA_W] != '0);

    if (r.opcode inside {OP_ADD, OP_SUB, OP_ADDI, OP_SLL, OP_SRL, OP_MOV})
    begin
        e.wb_valid      = live;
        e.wb_req.rf_wen = 1'b1;
    end
    else if (r.opcode inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGT, OP_BLE, OP_BGE, OP_JUMP})
    begin
        e.wb_valid    = live;
        e.take_branch = live & branch_holds(r.opcode, r.ra_data, r.rb_data);
        e.branch_pc   = {{(PC_W-OFFSET_W){1'b0}}, r.offset};
    end
    else if (r.opcode inside {OP_LDB, OP_LDW, OP_STB, OP_STW})
    begin
        store  = (r.opcode == OP_STB) || (r.opcode == OP_STW);
        oldest = (tail == r.instr_id) && ready;
        e.mem_req.addr     = (store ? r.rb_data : r.ra_data) + imm;
        e.mem_req.is_store = store;
        e.mem_req.size     = (r.opcode == OP_LDB || r.opcode == OP_STB) ? SIZE_BYTE : SIZE_WORD;
        e.dcache_valid     = live & oldest;
        e.wb_mem_blocked   = live & ~oldest;
    end
    return e;
endfunction

`endif

/* bench/alu_tb.sv */
`timescale 1ns/1ps

module alu_tb;
    import alu_pkg::*;

    localparam int CLK_PERIOD    = 100;
    localparam int RESET_CYCLES  = 16;
    localparam int RANDOM_CYCLES = 200;
    // Directed tests and drain cycles fit well inside 100 cycles
    localparam int TEST_CYCLES   = RESET_CYCLES + 100 + RANDOM_CYCLES;
    localparam int MARGIN_CYCLES = 50;

    `include "alu_ref.svh"

    logic                clock;
    logic                rst_n;
    logic                flush;
    logic                dcache_ready;
    logic [ROB_ID_W-1:0] rob_tail;
    logic                req_valid;
    alu_req_t            req;
    logic                dcache_valid;
    dcache_req_t         dcache_req;
    logic                wb_valid;
    wb_req_t             wb_req;
    logic                wb_mem_blocked;
    dcache_req_t         wb_dcache_req;
    logic                take_branch;
    logic [PC_W-1:0]     branch_pc;

    expect_t             exp_q[$];
    integer              seed;
    logic [ROB_ID_W-1:0] next_id;
    int                  errors;
    int                  checks;
    int                  errors_at_start;
    int                  tests_passed;
    int                  tests_failed;

    alu_top alu_top_inst
    (
        .clock          (clock),
        .rst_n          (rst_n),
        .flush          (flush),
        .dcache_ready   (dcache_ready),
        .rob_tail       (rob_tail),
        .req_valid      (req_valid),
        .req            (req),
        .dcache_valid   (dcache_valid),
        .dcache_req     (dcache_req),
        .wb_valid       (wb_valid),
        .wb_req         (wb_req),
        .wb_mem_blocked (wb_mem_blocked),
        .wb_dcache_req  (wb_dcache_req),
        .take_branch    (take_branch),
        .branch_pc      (branch_pc)
    );

    initial
    begin
        clock = 1'b0;
        forever
        begin
            #(CLK_PERIOD/2) clock = ~clock;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checking
    //////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string name, input logic [159:0] expected,
                                   input logic [159:0] actual);
        errors++;
        $display("Fail at %0t ns: %s expected %0h, actual %0h", $time, name, expected, actual);
    endtask

    task automatic check_outputs(input expect_t e);
        checks++;
        if (dcache_valid !== e.dcache_valid)
            report_mismatch("dcache_valid", 160'(e.dcache_valid), 160'(dcache_valid));
        if (wb_valid !== e.wb_valid)
            report_mismatch("wb_valid", 160'(e.wb_valid), 160'(wb_valid));
        if (wb_mem_blocked !== e.wb_mem_blocked)
            report_mismatch("wb_mem_blocked", 160'(e.wb_mem_blocked), 160'(wb_mem_blocked));
        if (take_branch !== e.take_branch)
            report_mismatch("take_branch", 160'(e.take_branch), 160'(take_branch));
        if (e.wb_valid)
        begin
            if (wb_req.instr_id !== e.wb_req.instr_id)
                report_mismatch("wb_req.instr_id", 160'(e.wb_req.instr_id), 160'(wb_req.instr_id));
            if (wb_req.pc !== e.wb_req.pc)
                report_mismatch("wb_req.pc", 160'(e.wb_req.pc), 160'(wb_req.pc));
            if (wb_req.rf_wen !== e.wb_req.rf_wen)
                report_mismatch("wb_req.rf_wen", 160'(e.wb_req.rf_wen), 160'(wb_req.rf_wen));
            if (wb_req.rf_dest !== e.wb_req.rf_dest)
                report_mismatch("wb_req.rf_dest", 160'(e.wb_req.rf_dest), 160'(wb_req.rf_dest));
        end
        // Result and overflow only matter for register writes
        if (e.wb_valid && e.wb_req.rf_wen)
        begin
            if (wb_req.rf_data !== e.wb_req.rf_data)
                report_mismatch("wb_req.rf_data", 160'(e.wb_req.rf_data), 160'(wb_req.rf_data));
            if (wb_req.xcpt_overflow !== e.wb_req.xcpt_overflow)
                report_mismatch("wb_req.xcpt_overflow", 160'(e.wb_req.xcpt_overflow),
                                160'(wb_req.xcpt_overflow));
        end
        if (e.take_branch && branch_pc !== e.branch_pc)
            report_mismatch("branch_pc", 160'(e.branch_pc), 160'(branch_pc));
        if (e.dcache_valid && dcache_req !== e.mem_req)
            report_mismatch("dcache_req", 160'(e.mem_req), 160'(dcache_req));
        if (e.wb_mem_blocked && wb_dcache_req !== e.mem_req)
            report_mismatch("wb_dcache_req", 160'(e.mem_req), 160'(wb_dcache_req));
    endtask

    // Expectation pushed after edge N-1 is sampled at edge N, checked half a cycle later
    initial
    begin : compare_proc
        expect_t e;
        forever
        begin
            @(posedge clock);
            if (exp_q.size() > 0)
            begin
                e = exp_q.pop_front();
                @(negedge clock);
                check_outputs(e);
            end
        end
    end

    initial
    begin
        #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Timeout: run still going after %0d cycles", TEST_CYCLES + MARGIN_CYCLES);
        $display("Something failed");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    function automatic alu_req_t make_req(input logic [OPCODE_W-1:0] op,
                                          input logic [DATA_W-1:0]   ra,
                                          input logic [DATA_W-1:0]   rb,
                                          input logic [OFFSET_W-1:0] off);
        alu_req_t r;
        r.opcode   = op;
        r.rd_addr  = next_id[REG_ADDR_W-1:0];
        r.ra_data  = ra;
        r.rb_data  = rb;
        r.offset   = off;
        r.instr_id = next_id;
        r.pc       = {20'h00001, 4'h0, next_id, 2'b00};
        next_id    = next_id + 6'd1;
        return r;
    endfunction

    task automatic drive_cycle(input logic valid, input alu_req_t r,
                               input logic [ROB_ID_W-1:0] tail, input logic ready,
                               input logic flush_in);
        @(posedge clock);
        #1;
        req_valid    = valid;
        req          = r;
        rob_tail     = tail;
        dcache_ready = ready;
        flush        = flush_in;
        exp_q.push_back(expected_outputs(r, valid, tail, ready, flush_in));
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, '0, '0, 1'b0, 1'b0);
    endtask

    task automatic finish_test(input string name);
        idle_cycle();
        while (exp_q.size() != 0)
            @(negedge clock);
        #1;
        if (errors == errors_at_start)
        begin
            tests_passed++;
            $display("Test %s: passed", name);
        end
        else
        begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////

    task automatic alu_ops_test();
        // Quiet cycles right after reset
        idle_cycle();
        idle_cycle();
        drive_cycle(1'b1, make_req(OP_ADD, 32'd5, 32'd7, 20'd0), '0, 1'b1, 1'b0);
        drive_cycle(1'b1, make_req(OP_ADD, 32'hffff_ffff, 32'd1, 20'd0), '0, 1'b1, 1'b0);
        drive_cycle(1'b1, make_req(OP_SUB, 32'd10, 32'd4, 20'd0), '0, 1'b1, 1'b0);
        drive_cycle(1'b1, make_req(OP_SUB, 32'd3, 32'd5, 20'd0), '0, 1'b1, 1'b0);
        drive_cycle(1'b1, make_req(OP_ADDI, 32'd100, 32'd0, 20'hfffff), '0, 1'b0, 1'b0);
        drive_cycle(1'b1, make_req(OP_ADDI, 32'hffff_fff0, 32'd0, 20'h00020), '0, 1'b0, 1'b0);
        drive_cycle(1'b1, make_req(OP_SLL, 32'h0000_0001, 32'd0, 20'd4), '0, 1'b1, 1'b0);
        drive_cycle(1'b1, make_req(OP_SLL, 32'h8000_0001, 32'd0, 20'd1), '0, 1'b1, 1'b0);
        drive_cycle(1'b1, make_req(OP_SRL, 32'hf000_0000, 32'd0, 20'd28), '0, 1'b1, 1'b0);
        drive_cycle(1'b1, make_req(OP_MOV, 32'hdead_beef, 32'd0, 20'd0), '0, 1'b1, 1'b0);
    endtask

    task automatic branch_test();
        logic [OPCODE_W-1:0] ops[$]    = '{OP_BEQ, OP_BNE, OP_BLT, OP_BGT, OP_BLE, OP_BGE};
        logic [DATA_W-1:0]   ra_vals[$] = '{32'd5, 32'd3, 32'd9, 32'h8000_0000};
        logic [DATA_W-1:0]   rb_vals[$] = '{32'd5, 32'd9, 32'd3, 32'h0000_0001};
        // Equal, lower, higher, and a top-bit case for the unsigned rule
        for (int i = 0; i < ops.size(); i++)
        begin
            for (int j = 0; j < ra_vals.size(); j++)
                drive_cycle(1'b1, make_req(ops[i], ra_vals[j], rb_vals[j], 20'h00a40),
                            '0, 1'b0, 1'b0);
        end
        drive_cycle(1'b1, make_req(OP_JUMP, 32'd1, 32'd2, 20'hffffc), '0, 1'b0, 1'b0);
    endtask

    task automatic mem_test(input logic blocked);
        logic [OPCODE_W-1:0] ops[$] = '{OP_LDB, OP_LDW, OP_STB, OP_STW};
        alu_req_t            r;
        for (int i = 0; i < ops.size(); i++)
        begin
            r = make_req(ops[i], 32'h0000_1000, 32'h0002_0000, 20'h00044);
            drive_cycle(1'b1, r, blocked ? r.instr_id + 6'd1 : r.instr_id, 1'b1, 1'b0);
            // Address wraps past the top
            r = make_req(ops[i], 32'hffff_fff0, 32'hffff_ff00, 20'hfff20);
            drive_cycle(1'b1, r, r.instr_id, ~blocked, 1'b0);
        end
    endtask

    task automatic flush_random_test();
        logic [OPCODE_W-1:0] ops[$] = '{OP_ADD, OP_SUB, OP_ADDI, OP_SLL, OP_SRL, OP_MOV,
                                        OP_BEQ, OP_BNE, OP_BLT, OP_BGT, OP_BLE, OP_BGE,
                                        OP_JUMP, OP_LDB, OP_LDW, OP_STB, OP_STW, 7'h7f};
        alu_req_t            r;
        logic [31:0]         rnd;
        logic [DATA_W-1:0]   ra;
        logic [DATA_W-1:0]   rb;
        logic [OFFSET_W-1:0] off;
        logic [ROB_ID_W-1:0] tail;
        int                  idx;
        drive_cycle(1'b1, make_req(OP_ADD, 32'd1, 32'd2, 20'd0), '0, 1'b1, 1'b1);
        drive_cycle(1'b1, make_req(OP_JUMP, 32'd0, 32'd0, 20'h00100), '0, 1'b1, 1'b1);
        r = make_req(OP_LDW, 32'd64, 32'd0, 20'd4);
        drive_cycle(1'b1, r, r.instr_id, 1'b1, 1'b1);
        drive_cycle(1'b1, make_req(OP_STW, 32'd7, 32'd64, 20'd8), '0, 1'b0, 1'b1);
        repeat (RANDOM_CYCLES)
        begin
            rnd  = $random(seed);
            idx  = int'(rnd[15:0]) % ops.size();
            ra   = $random(seed);
            rb   = rnd[16] ? ra : $random(seed);
            off  = rnd[17] ? {14'd0, rnd[23:18]} : rnd[31:12];
            r    = make_req(ops[idx], ra, rb, off);
            tail = rnd[24] ? r.instr_id : rnd[30:25];
            drive_cycle(1'b1, r, tail, rnd[25], rnd[28:26] == 3'b000);
        end
    endtask

    initial
    begin
        seed            = 32'h9a3d2ad1;
        rst_n           = 1'b0;
        flush           = 1'b0;
        dcache_ready    = 1'b0;
        rob_tail        = '0;
        req_valid       = 1'b0;
        req             = '0;
        next_id         = '0;
        errors          = 0;
        checks          = 0;
        errors_at_start = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        rst_n = 1'b1;

        alu_ops_test();
        finish_test("alu_ops");
        branch_test();
        finish_test("branches");
        mem_test(1'b0);
        finish_test("mem_to_cache");
        mem_test(1'b1);
        finish_test("mem_blocked");
        flush_random_test();
        finish_test("flush_random");

        $display("Tests passed %0d, failed %0d, checks %0d, errors %0d",
                 tests_passed, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

/* tb.f */
+incdir+bench
verilog/alu_pkg.sv
verilog/alu_decode.sv
verilog/alu_arith.sv
verilog/alu_branch.sv
verilog/alu_agen.sv
verilog/alu_route.sv
verilog/alu_top.sv
bench/alu_tb.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing -f tb.f --top-module alu_tb -o alu_sim \
    && ./obj_dir/alu_sim | tee /dev/stderr | grep "Everything OK" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
